/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = udp_rx_tb
FILELIST  = udp_rx_sys.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+1000
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/rx_buf_arbiter.sv */
module rx_buf_arbiter import udp_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr_en,
    input  buf_addr_t wr_addr,
    input  word_t     wr_data,
    input  logic      rd_req,
    input  buf_addr_t rd_addr,
    output logic      rd_ack,
    output word_t     rd_data
);

    word_t     mem [BUF_WORDS];
    logic      rd_grant;
    buf_addr_t port_addr;

    // ******************************************************************
    // one port, writer first
    // ******************************************************************

    // rd_req is still high in the ack cycle, so no second grant there
    assign rd_grant  = rd_req && !wr_en && !rd_ack;
    assign port_addr = wr_en ? wr_addr : rd_addr;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[port_addr] <= wr_data;
        end else if (rd_grant) begin
            rd_data <= mem[port_addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ack <= 1'b0;
        end else begin
            rd_ack <= rd_grant;  // data valid alongside ack
        end
    end

endmodule

/* design/udp_axil_regs.sv */
module udp_axil_regs import udp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  axil_addr_t s_awaddr,
    input  logic       s_awvalid,
    output logic       s_awready,
    input  word_t      s_wdata,
    input  logic [3:0] s_wstrb,
    input  logic       s_wvalid,
    output logic       s_wready,
    output logic [1:0] s_bresp,
    output logic       s_bvalid,
    input  logic       s_bready,
    input  axil_addr_t s_araddr,
    input  logic       s_arvalid,
    output logic       s_arready,
    output word_t      s_rdata,
    output logic [1:0] s_rresp,
    output logic       s_rvalid,
    input  logic       s_rready,
    input  logic       pkt_done,
    input  byte_cnt_t  pkt_bytes,
    input  logic       pkt_drop,
    output mac_addr_t  board_mac,
    output ip_addr_t   board_ip,
    output logic       rd_req,
    output buf_addr_t  rd_addr,
    input  logic       rd_ack,
    input  word_t      rd_data
);

    logic      ready;
    byte_cnt_t rx_bytes;
    word_t     pkt_count;
    word_t     drop_count;
    logic      wr_fire;
    logic      rd_fire;
    word_t     wr_mask;    // byte lanes from wstrb
    word_t     reg_rdata;

    assign wr_fire   = s_awvalid && s_wvalid && !s_bvalid;
    assign s_awready = wr_fire;
    assign s_wready  = wr_fire;
    assign s_bresp   = 2'b00;  // always OKAY
    assign s_rresp   = 2'b00;
    assign s_arready = s_arvalid && !rd_req && !s_rvalid;  // one read at a time
    assign rd_fire   = s_arready;
    assign wr_mask   = {{8{s_wstrb[3]}}, {8{s_wstrb[2]}}, {8{s_wstrb[1]}}, {8{s_wstrb[0]}}};

    // ******************************************************************
    // configuration, status and counters
    // ******************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            board_mac  <= DEFAULT_BOARD_MAC;
            board_ip   <= DEFAULT_BOARD_IP;
            ready      <= 1'b0;
            rx_bytes   <= '0;
            pkt_count  <= '0;
            drop_count <= '0;
        end else begin
            if (wr_fire) begin
                case (s_awaddr)
                    REG_BOARD_IP: board_ip <= (board_ip & ~wr_mask) | (s_wdata & wr_mask);
                    REG_MAC_LO: board_mac[31:0] <= (board_mac[31:0] & ~wr_mask)
                                                   | (s_wdata & wr_mask);
                    REG_MAC_HI: board_mac[47:32] <= (board_mac[47:32] & ~wr_mask[15:0])
                                                    | (s_wdata[15:0] & wr_mask[15:0]);
                    REG_CTRL: if (s_wstrb[0] && s_wdata[0]) ready <= 1'b0;
                    default: ;
                endcase
            end
            if (pkt_done) begin  // a new packet wins over a clear
                ready     <= 1'b1;
                rx_bytes  <= pkt_bytes;
                pkt_count <= pkt_count + 32'd1;
            end
            if (pkt_drop) drop_count <= drop_count + 32'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) s_bvalid <= 1'b0;
        else if (wr_fire) s_bvalid <= 1'b1;
        else if (s_bready) s_bvalid <= 1'b0;
    end

    // register read mux, unmapped reads zero
    always_comb begin
        case (s_araddr)
            REG_STATUS:     reg_rdata = {31'd0, ready};
            REG_RX_BYTES:   reg_rdata = {16'd0, rx_bytes};
            REG_PKT_COUNT:  reg_rdata = pkt_count;
            REG_DROP_COUNT: reg_rdata = drop_count;
            REG_BOARD_IP:   reg_rdata = board_ip;
            REG_MAC_LO:     reg_rdata = board_mac[31:0];
            REG_MAC_HI:     reg_rdata = {16'd0, board_mac[47:32]};
            default:        reg_rdata = '0;
        endcase
    end

    // ******************************************************************
    // read channel, buffer window goes through the arbiter
    // ******************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_rvalid <= 1'b0;
            rd_req   <= 1'b0;
        end else if (rd_fire && s_araddr >= BUF_BASE) begin
            rd_req <= 1'b1;  // held until ack
        end else if (rd_fire) begin
            s_rvalid <= 1'b1;
        end else if (rd_ack) begin
            rd_req   <= 1'b0;
            s_rvalid <= 1'b1;
        end else if (s_rready) begin
            s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            s_rdata <= reg_rdata;
            rd_addr <= s_araddr[7:2];
        end else if (rd_ack) begin
            s_rdata <= rd_data;
        end
    end

endmodule

/* design/udp_pkg.sv */
package udp_pkg;

    // ******************************************************************
    // widths with a meaning
    // ******************************************************************
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [31:0] word_t;      // payload word or register data
    typedef logic [15:0] byte_cnt_t;
    typedef logic [5:0]  buf_addr_t;  // word index into the packet buffer
    typedef logic [8:0]  axil_addr_t;

    localparam int BUF_WORDS = 64;    // 256 payload bytes

    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;

    // identity after reset, host may change it
    localparam mac_addr_t DEFAULT_BOARD_MAC = 48'h02_00_5e_10_00_01;
    localparam ip_addr_t  DEFAULT_BOARD_IP  = 32'hc0a8_010a;  // 192.168.1.10

    // ******************************************************************
    // register map
    // ******************************************************************
    localparam axil_addr_t REG_STATUS     = 9'h000;  // bit 0 ready
    localparam axil_addr_t REG_RX_BYTES   = 9'h004;
    localparam axil_addr_t REG_PKT_COUNT  = 9'h008;
    localparam axil_addr_t REG_DROP_COUNT = 9'h00c;
    localparam axil_addr_t REG_BOARD_IP   = 9'h010;
    localparam axil_addr_t REG_MAC_LO     = 9'h014;
    localparam axil_addr_t REG_MAC_HI     = 9'h018;  // upper 16 bits of mac
    localparam axil_addr_t REG_CTRL       = 9'h01c;  // bit 0 clears ready
    localparam axil_addr_t BUF_BASE       = 9'h100;  // word n at BUF_BASE + 4n

endpackage

/* design/udp_rx.sv */
module udp_rx import udp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  mac_addr_t  board_mac,
    input  ip_addr_t   board_ip,
    input  logic       gmii_rx_dv,
    input  logic [7:0] gmii_rxd,
    output logic       buf_wr_en,
    output buf_addr_t  buf_wr_addr,
    output word_t      buf_wr_data,
    output logic       pkt_done,
    output byte_cnt_t  pkt_bytes,
    output logic       pkt_drop
);

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_eth_head,
        st_ip_head,
        st_udp_head,
        st_rx_data,
        st_rx_end
    } rx_state_t;

    rx_state_t   state;
    logic [5:0]  cnt;        // byte index inside current header
    byte_cnt_t   data_cnt;   // payload bytes taken so far
    mac_addr_t   dst_mac;
    logic [7:0]  type_hi;
    logic [23:0] ip_head3;   // first three bytes of destination ip
    logic [3:0]  ihl;
    byte_cnt_t   udp_len;
    logic [23:0] word_sr;    // payload bytes of the word in progress

    logic        mac_ok;
    logic        type_ok;
    logic        ip_ok;
    logic [5:0]  ip_last;    // index of the final ip header byte
    logic        last_byte;
    logic        word_end;
    word_t       pack_word;

    assign mac_ok    = (dst_mac == board_mac) || (dst_mac == '1);  // board or broadcast
    assign type_ok   = {type_hi, gmii_rxd} == ETH_TYPE_IPV4;
    assign ip_ok     = {ip_head3, gmii_rxd} == board_ip;
    assign ip_last   = {ihl, 2'b00} - 6'd1;
    assign last_byte = data_cnt == pkt_bytes - 16'd1;
    assign word_end  = (data_cnt[1:0] == 2'd3) || last_byte;
    assign pack_word = {word_sr, gmii_rxd};

    // ******************************************************************
    // frame walk, one byte per clk
    // ******************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            cnt       <= '0;
            data_cnt  <= '0;
            buf_wr_en <= 1'b0;
            pkt_done  <= 1'b0;
            pkt_drop  <= 1'b0;
        end else begin
            buf_wr_en <= 1'b0;
            pkt_done  <= 1'b0;
            pkt_drop  <= 1'b0;
            if (!gmii_rx_dv) begin
                state <= st_idle;  // end of frame or truncated frame
                cnt   <= '0;
            end else begin
                cnt <= cnt + 6'd1;
                case (state)
                    st_idle: begin
                        if (gmii_rxd == 8'h55) begin
                            state <= st_preamble;
                        end else begin
                            pkt_drop <= 1'b1;
                            state    <= st_rx_end;
                        end
                    end
                    st_preamble: begin
                        if (cnt == 6'd7) begin  // sfd slot
                            cnt <= '0;
                            if (gmii_rxd == 8'hd5) begin
                                state <= st_eth_head;
                            end else begin
                                pkt_drop <= 1'b1;
                                state    <= st_rx_end;
                            end
                        end else if (gmii_rxd != 8'h55) begin
                            pkt_drop <= 1'b1;
                            state    <= st_rx_end;
                        end
                    end
                    st_eth_head: begin
                        if (cnt == 6'd13) begin
                            cnt <= '0;
                            if (mac_ok && type_ok) begin
                                state <= st_ip_head;
                            end else begin
                                pkt_drop <= 1'b1;
                                state    <= st_rx_end;
                            end
                        end
                    end
                    st_ip_head: begin
                        if (cnt == 6'd19 && !ip_ok) begin
                            pkt_drop <= 1'b1;
                            state    <= st_rx_end;
                        end else if (cnt >= 6'd19 && cnt >= ip_last) begin
                            cnt   <= '0;  // options skipped
                            state <= st_udp_head;
                        end
                    end
                    st_udp_head: begin
                        if (cnt == 6'd7) begin
                            cnt      <= '0;
                            data_cnt <= '0;
                            if (udp_len <= 16'd8) begin
                                pkt_done <= 1'b1;  // empty payload
                                state    <= st_rx_end;
                            end else begin
                                state <= st_rx_data;
                            end
                        end
                    end
                    st_rx_data: begin
                        data_cnt <= data_cnt + 16'd1;
                        if (word_end) begin
                            // words past the buffer are counted, not stored
                            buf_wr_en <= data_cnt < byte_cnt_t'(BUF_WORDS * 4);
                        end
                        if (last_byte) begin
                            pkt_done <= 1'b1;
                            state    <= st_rx_end;
                        end
                    end
                    default: ;  // st_rx_end, wait for dv to fall
                endcase
            end
        end
    end

    // header fields and payload packing
    always_ff @(posedge clk) begin
        if (gmii_rx_dv) begin
            case (state)
                st_eth_head: begin
                    if (cnt < 6'd6) dst_mac <= {dst_mac[39:0], gmii_rxd};
                    if (cnt == 6'd12) type_hi <= gmii_rxd;
                end
                st_ip_head: begin
                    if (cnt == 6'd0) ihl <= gmii_rxd[3:0];
                    if (cnt >= 6'd16 && cnt <= 6'd18) ip_head3 <= {ip_head3[15:0], gmii_rxd};
                end
                st_udp_head: begin
                    if (cnt == 6'd4) udp_len[15:8] <= gmii_rxd;
                    if (cnt == 6'd5) udp_len[7:0] <= gmii_rxd;
                    if (cnt == 6'd7) pkt_bytes <= (udp_len > 16'd8) ? udp_len - 16'd8 : '0;
                end
                st_rx_data: begin
                    word_sr <= pack_word[23:0];
                    if (word_end) begin
                        buf_wr_addr <= data_cnt[7:2];
                        buf_wr_data <= pack_word << {~data_cnt[1:0], 3'b000};  // zero pad
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* design/udp_rx_top.sv */
module udp_rx_top import udp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       gmii_rx_dv,
    input  logic [7:0] gmii_rxd,
    input  axil_addr_t s_awaddr,
    input  logic       s_awvalid,
    output logic       s_awready,
    input  word_t      s_wdata,
    input  logic [3:0] s_wstrb,
    input  logic       s_wvalid,
    output logic       s_wready,
    output logic [1:0] s_bresp,
    output logic       s_bvalid,
    input  logic       s_bready,
    input  axil_addr_t s_araddr,
    input  logic       s_arvalid,
    output logic       s_arready,
    output word_t      s_rdata,
    output logic [1:0] s_rresp,
    output logic       s_rvalid,
    input  logic       s_rready
);

    mac_addr_t board_mac;
    ip_addr_t  board_ip;
    logic      buf_wr_en;
    buf_addr_t buf_wr_addr;
    word_t     buf_wr_data;
    logic      pkt_done;
    byte_cnt_t pkt_bytes;
    logic      pkt_drop;
    logic      rd_req;
    buf_addr_t rd_addr;
    logic      rd_ack;
    word_t     rd_data;

    // receiver writes, host reads, arbiter in between
    udp_rx rx0 (
        .clk(clk), .rst_n(rst_n), .board_mac(board_mac), .board_ip(board_ip),
        .gmii_rx_dv(gmii_rx_dv), .gmii_rxd(gmii_rxd), .buf_wr_en(buf_wr_en),
        .buf_wr_addr(buf_wr_addr), .buf_wr_data(buf_wr_data), .pkt_done(pkt_done),
        .pkt_bytes(pkt_bytes), .pkt_drop(pkt_drop)
    );

    rx_buf_arbiter arb0 (
        .clk(clk), .rst_n(rst_n), .wr_en(buf_wr_en), .wr_addr(buf_wr_addr),
        .wr_data(buf_wr_data), .rd_req(rd_req), .rd_addr(rd_addr),
        .rd_ack(rd_ack), .rd_data(rd_data)
    );

    udp_axil_regs regs0 (
        .clk(clk), .rst_n(rst_n),
        .s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
        .s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
        .s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
        .s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
        .s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
        .pkt_done(pkt_done), .pkt_bytes(pkt_bytes), .pkt_drop(pkt_drop),
        .board_mac(board_mac), .board_ip(board_ip),
        .rd_req(rd_req), .rd_addr(rd_addr), .rd_ack(rd_ack), .rd_data(rd_data)
    );

endmodule

/* tests/udp_rx_tb.sv */
module udp_rx_tb import udp_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int        MAX_TESTS  = 32;
    localparam int        IFG_CYCLES = 12;
    localparam mac_addr_t OTHER_MAC  = 48'h02_00_5e_10_00_77;
    localparam mac_addr_t SRC_MAC    = 48'h02_00_00_00_00_09;
    localparam ip_addr_t  SRC_IP     = 32'hc0a8_0101;

    logic       clk;
    logic       rst_n;
    logic       gmii_rx_dv;
    logic [7:0] gmii_rxd;
    axil_addr_t s_awaddr;
    logic       s_awvalid;
    logic       s_awready;
    word_t      s_wdata;
    logic [3:0] s_wstrb;
    logic       s_wvalid;
    logic       s_wready;
    logic [1:0] s_bresp;
    logic       s_bvalid;
    logic       s_bready;
    axil_addr_t s_araddr;
    logic       s_arvalid;
    logic       s_arready;
    word_t      s_rdata;
    logic [1:0] s_rresp;
    logic       s_rvalid;
    logic       s_rready;

    // test table, one entry per data line
    int          n_tests;
    int          t_id     [MAX_TESTS];
    ip_addr_t    t_new_ip [MAX_TESTS];
    int          t_mac_sel[MAX_TESTS];
    ip_addr_t    t_dst_ip [MAX_TESTS];
    logic [15:0] t_etype  [MAX_TESTS];
    logic [3:0]  t_ihl    [MAX_TESTS];
    int          t_len    [MAX_TESTS];
    logic        t_clr    [MAX_TESTS];
    logic        t_accept [MAX_TESTS];

    logic      exp_ready;   // expected register state
    byte_cnt_t exp_bytes;
    word_t     exp_pkts;
    word_t     exp_drops;

    logic [7:0] payload [256];
    logic [7:0] frame [$];
    integer     seed;
    int         errors;
    int         tests_run;
    int         tests_failed;
    int         cycle_cnt   = 0;
    int         cycle_limit = 1000;  // reset and default reads

    udp_rx_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_id, f_ip, f_mac, f_dip, f_type, f_ihl, f_len, f_clr, f_acc;
        n_tests = 0;
        fd = $fopen("tests/udp_rx_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file tests/udp_rx_tests.txt");
            errors++;
        end else begin
            while (!$feof(fd) && n_tests < MAX_TESTS) begin
                if ($fgets(line, fd) == 0) break;
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                            f_id, f_ip, f_mac, f_dip, f_type, f_ihl, f_len, f_clr, f_acc);
                if (n == 9) begin  // comment lines fall through
                    t_id[n_tests]      = f_id;
                    t_new_ip[n_tests]  = f_ip;
                    t_mac_sel[n_tests] = f_mac;
                    t_dst_ip[n_tests]  = f_dip;
                    t_etype[n_tests]   = f_type[15:0];
                    t_ihl[n_tests]     = f_ihl[3:0];
                    t_len[n_tests]     = f_len;
                    t_clr[n_tests]     = f_clr[0];
                    t_accept[n_tests]  = f_acc[0];
                    cycle_limit = cycle_limit + 8 + 14 + 4 * t_ihl[n_tests] + 8 + t_len[n_tests]
                                  + 4 + IFG_CYCLES + 20 * ((t_len[n_tests] + 3) / 4) + 200;
                    n_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic show_mismatch(input string name, input word_t exp, input word_t got);
        $display("error %s: expected %h, got %h", name, exp, got);
        errors++;
    endtask

    // ******************************************************************
    // axi4-lite host, ready sampled at the falling edge
    // ******************************************************************
    task automatic write_reg(input axil_addr_t addr, input word_t data);
        @(posedge clk);
        #1;
        s_awaddr  = addr;
        s_wdata   = data;
        s_wstrb   = 4'hf;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        @(negedge clk);
        while (!s_awready) @(negedge clk);
        if (s_wready !== 1'b1) show_mismatch("WREADY", 32'h1, {31'd0, s_wready});
        @(posedge clk);
        #1;
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b1;
        @(negedge clk);
        while (!s_bvalid) @(negedge clk);
        if (s_bresp !== 2'b00) show_mismatch("BRESP", 32'h0, {30'd0, s_bresp});
        @(posedge clk);
        #1;
        s_bready = 1'b0;
    endtask

    task automatic read_reg(input axil_addr_t addr, output word_t data);
        @(posedge clk);
        #1;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        @(negedge clk);
        while (!s_arready) @(negedge clk);
        @(posedge clk);
        #1;
        s_arvalid = 1'b0;
        s_rready  = 1'b1;
        @(negedge clk);
        while (!s_rvalid) @(negedge clk);  // buffer reads take longer
        data = s_rdata;
        if (s_rresp !== 2'b00) show_mismatch("RRESP", 32'h0, {30'd0, s_rresp});
        @(posedge clk);
        #1;
        s_rready = 1'b0;
    endtask

    // ******************************************************************
    // gmii frame
    // ******************************************************************
    task automatic build_frame(input int i);
        mac_addr_t    dst;
        int           ip_len;
        int           udp_len;
        int           k;
        logic [151:0] ip_rest;   // ipv4 header after its first byte
        logic [63:0]  udp_hdr;
        frame.delete();
        case (t_mac_sel[i])
            0:       dst = DEFAULT_BOARD_MAC;
            1:       dst = '1;
            default: dst = OTHER_MAC;
        endcase
        ip_len  = 4 * t_ihl[i];
        udp_len = t_len[i] + 8;
        ip_rest = {8'h00, 16'(ip_len + udp_len), 32'h0000_4000, 8'h40, 8'h11, 16'h0000,
                   SRC_IP, t_dst_ip[i]};
        udp_hdr = {16'h1234, 16'h0400, 16'(udp_len), 16'h0000};  // checksum unused
        repeat (7) frame.push_back(8'h55);
        frame.push_back(8'hd5);
        for (k = 5; k >= 0; k--) frame.push_back(dst[8*k +: 8]);
        for (k = 5; k >= 0; k--) frame.push_back(SRC_MAC[8*k +: 8]);
        frame.push_back(t_etype[i][15:8]);
        frame.push_back(t_etype[i][7:0]);
        frame.push_back({4'h4, t_ihl[i]});
        for (k = 18; k >= 0; k--) frame.push_back(ip_rest[8*k +: 8]);
        for (k = 20; k < ip_len; k++) frame.push_back(8'h00);  // options
        for (k = 7; k >= 0; k--) frame.push_back(udp_hdr[8*k +: 8]);
        for (k = 0; k < t_len[i]; k++) frame.push_back(payload[k]);
        repeat (4) frame.push_back(8'h00);  // fcs slot, not checked
    endtask

    task automatic send_frame();
        foreach (frame[k]) begin
            @(posedge clk);
            #1;
            gmii_rx_dv = 1'b1;
            gmii_rxd   = frame[k];
        end
        @(posedge clk);
        #1;
        gmii_rx_dv = 1'b0;
        gmii_rxd   = 8'h00;
        repeat (IFG_CYCLES) @(posedge clk);
    endtask

    // poll counters until the frame is counted one way or the other
    task automatic wait_frame_result();
        word_t pkts;
        word_t drops;
        pkts  = exp_pkts;
        drops = exp_drops;
        while (pkts == exp_pkts && drops == exp_drops) begin
            read_reg(REG_PKT_COUNT, pkts);
            read_reg(REG_DROP_COUNT, drops);
        end
    endtask

    task automatic report_test(input int id, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %0d: ok", id);
        end else begin
            $display("test %0d: %0d mismatches", id, errors - start_errors);
            tests_failed++;
        end
    endtask

    task automatic check_defaults();
        int    start_errors;
        word_t got;
        start_errors = errors;
        read_reg(REG_BOARD_IP, got);
        if (got !== DEFAULT_BOARD_IP) show_mismatch("BOARD_IP", DEFAULT_BOARD_IP, got);
        read_reg(REG_MAC_LO, got);
        if (got !== DEFAULT_BOARD_MAC[31:0]) show_mismatch("MAC_LO", DEFAULT_BOARD_MAC[31:0], got);
        read_reg(REG_MAC_HI, got);
        if (got !== {16'd0, DEFAULT_BOARD_MAC[47:32]}) begin
            show_mismatch("MAC_HI", {16'd0, DEFAULT_BOARD_MAC[47:32]}, got);
        end
        read_reg(REG_STATUS, got);
        if (got !== 32'h0) show_mismatch("STATUS", 32'h0, got);
        read_reg(REG_PKT_COUNT, got);
        if (got !== 32'h0) show_mismatch("PKT_COUNT", 32'h0, got);
        read_reg(REG_DROP_COUNT, got);
        if (got !== 32'h0) show_mismatch("DROP_COUNT", 32'h0, got);
        report_test(0, start_errors);
    endtask

    task automatic run_test(input int i);
        int          start_errors;
        int          k;
        int          w;
        word_t       got;
        word_t       exp_word;
        logic [31:0] rnd;
        start_errors = errors;
        if (t_new_ip[i] != '0) begin
            write_reg(REG_BOARD_IP, t_new_ip[i]);
            read_reg(REG_BOARD_IP, got);
            if (got !== t_new_ip[i]) show_mismatch("BOARD_IP", t_new_ip[i], got);
        end
        if (t_clr[i]) begin
            write_reg(REG_CTRL, 32'h1);
            exp_ready = 1'b0;
            read_reg(REG_STATUS, got);
            if (got !== 32'h0) show_mismatch("STATUS", 32'h0, got);
        end
        for (k = 0; k < t_len[i]; k++) begin
            rnd = $random(seed);
            payload[k] = rnd[7:0];
        end
        build_frame(i);
        send_frame();
        wait_frame_result();
        if (t_accept[i]) begin
            exp_ready = 1'b1;
            exp_bytes = byte_cnt_t'(t_len[i]);
            exp_pkts  = exp_pkts + 32'd1;
        end else begin
            exp_drops = exp_drops + 32'd1;
        end
        read_reg(REG_STATUS, got);
        if (got !== {31'd0, exp_ready}) show_mismatch("STATUS", {31'd0, exp_ready}, got);
        read_reg(REG_RX_BYTES, got);
        if (got !== {16'd0, exp_bytes}) show_mismatch("RX_BYTES", {16'd0, exp_bytes}, got);
        read_reg(REG_PKT_COUNT, got);
        if (got !== exp_pkts) show_mismatch("PKT_COUNT", exp_pkts, got);
        read_reg(REG_DROP_COUNT, got);
        if (got !== exp_drops) show_mismatch("DROP_COUNT", exp_drops, got);
        if (t_accept[i]) begin
            for (w = 0; w < (t_len[i] + 3) / 4; w++) begin
                exp_word = '0;  // tail bytes stay zero
                for (k = 0; k < 4; k++) begin
                    if (4 * w + k < t_len[i]) exp_word[8*(3-k) +: 8] = payload[4*w + k];
                end
                read_reg(BUF_BASE + axil_addr_t'(4 * w), got);
                if (got !== exp_word) show_mismatch($sformatf("BUF[%0d]", w), exp_word, got);
            end
        end
        report_test(t_id[i], start_errors);
    endtask

    // ******************************************************************
    // main sequence
    // ******************************************************************
    initial begin
        int assert_fails;
        rst_n        = 1'b0;
        gmii_rx_dv   = 1'b0;
        gmii_rxd     = 8'h00;
        s_awaddr     = '0;
        s_awvalid    = 1'b0;
        s_wdata      = '0;
        s_wstrb      = 4'h0;
        s_wvalid     = 1'b0;
        s_bready     = 1'b0;
        s_araddr     = '0;
        s_arvalid    = 1'b0;
        s_rready     = 1'b0;
        seed         = 32'h62ba;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        exp_ready    = 1'b0;
        exp_bytes    = '0;
        exp_pkts     = '0;
        exp_drops    = '0;
        load_tests();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_defaults();
        for (int i = 0; i < n_tests; i++) run_test(i);
        assert_fails = dut0.arb0.arb_chk.fail_cnt + dut0.regs0.regs_chk.fail_cnt;
        $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 tests_run, tests_failed, errors, assert_fails);
        if (tests_failed == 0 && errors == 0 && assert_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* tests/udp_rx_tb_asserts.sv */
module udp_rx_tb_asserts import udp_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  req,         // buffer read request
    input logic  busy,        // write owns the port
    input logic  ack,
    input logic  resp_valid,  // write response channel
    input logic  resp_ready,
    input logic  data_valid,  // read data channel
    input logic  data_ready,
    input word_t data
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;

    // ******************************************************************
    // buffer port grant
    // ******************************************************************
    ack_after_free: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> $past(req && !busy))
    else begin
        $error("rd_ack without a free cycle before it");
        fail_cnt++;
    end

    ack_on_free: assert property (@(posedge clk) disable iff (!rst_n)
        req && !busy && !ack |=> ack)
    else begin
        $error("free cycle with a pending read gave no rd_ack");
        fail_cnt++;
    end

    // ******************************************************************
    // axi4-lite valids hold until taken
    // ******************************************************************
    resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid)
    else begin
        $error("bvalid dropped before bready");
        fail_cnt++;
    end

    data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        data_valid && !data_ready |=> data_valid && $stable(data))
    else begin
        $error("rvalid or rdata changed before rready");
        fail_cnt++;
    end

endmodule

bind rx_buf_arbiter udp_rx_tb_asserts arb_chk (
    .clk(clk), .rst_n(rst_n), .req(rd_req), .busy(wr_en), .ack(rd_ack),
    .resp_valid(1'b0), .resp_ready(1'b1), .data_valid(1'b0), .data_ready(1'b1),
    .data(32'h0)
);

bind udp_axil_regs udp_rx_tb_asserts regs_chk (
    .clk(clk), .rst_n(rst_n), .req(1'b0), .busy(1'b0), .ack(1'b0),
    .resp_valid(s_bvalid), .resp_ready(s_bready), .data_valid(s_rvalid),
    .data_ready(s_rready), .data(s_rdata)
);

/* tests/udp_rx_tests.txt */
# id new_ip mac dst_ip etype ihl len clr accept (all hex)
# mac 0 board, 1 broadcast, 2 other; new_ip 0 keeps the board ip
01 00000000 0 c0a8010a 0800 5 05 0 1
02 00000000 0 c0a8010a 0800 6 06 0 1
03 00000000 0 c0a8010a 0800 5 07 0 1
04 00000000 0 c0a8010a 0800 6 08 0 1
05 00000000 0 c0a8010a 0800 6 0d 0 1
06 00000000 1 c0a8010a 0800 5 0e 0 1
07 00000000 2 c0a8010a 0800 5 0a 0 0
08 00000000 0 c0a80199 0800 5 0a 0 0
09 00000000 0 c0a8010a 86dd 5 0c 0 0
0a c0a80120 0 c0a8010a 0800 5 09 0 0
0b 00000000 0 c0a80120 0800 6 09 0 1
0c 00000000 0 c0a80120 0800 5 04 1 1
0d 00000000 1 c0a80120 0800 5 fc 0 1

/* udp_rx_sys.f */
design/udp_pkg.sv
design/udp_rx.sv
design/rx_buf_arbiter.sv
design/udp_axil_regs.sv
design/udp_rx_top.sv
tests/udp_rx_tb_asserts.sv
tests/udp_rx_tb.sv
